// File: Makefile
TOP = tb_fxp_addsub_pipe

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): list.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f list.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee run.log
	grep -q "^>>> PASS$$" run.log

clean:
	rm -rf obj_dir run.log

// File: cla_add.sv
`default_nettype none
`timescale 1ns/10ps

module cla_add #(
    parameter int N = 32            // Datapath width in bits
) (
    input  wire  [N-1:0] a,         // Operand A
    input  wire  [N-1:0] b,         // Operand B
    input  wire          ci,        // Carry in
    output logic [N-1:0] c,         // Sum
    output logic         co         // Carry out
);

    // ----------------------------------------
    // Per-bit terms
    // ----------------------------------------

    // Generate, both bits set
    logic [N-1:0] g;
    // Propagate, either bit set
    logic [N-1:0] p;
    // Propagate without generate, i.e. the half-sum
    logic [N-1:0] pg;
    // Carry into each bit, plus the final carry
    logic [N:0]   k;

    assign g  = a & b;
    assign p  = a | b;
    assign pg = p & ~g;

    // ----------------------------------------
    // Carry chain
    // ----------------------------------------

    // Carry into bit 0 is the external carry in
    // Each next carry is generated here or propagated through
    always_comb begin
        k[0] = ci;
        for (int i = 0; i < N; i++) begin
            k[i+1] = g[i] | (p[i] & k[i]);
        end
    end

    // ----------------------------------------
    // Sum and carry out
    // ----------------------------------------

    // Half-sum xor incoming carry
    assign c  = pg ^ k[N-1:0];

    // Carry out of the MSB
    assign co = k[N];

endmodule : cla_add

`default_nettype wire

// File: fxp_add_stage.sv
`default_nettype none
`timescale 1ns/10ps

module fxp_add_stage
    import fxp_format_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               s1_valid,
    input  wire  [DATA_W-1:0] s1_a,
    input  wire  [DATA_W-1:0] s1_b,
    input  wire               s1_ci,
    input  wire               s1_sat,
    output logic              s2_valid,
    output logic [DATA_W-1:0] s2_sum,
    output logic              s2_co,
    output logic              s2_sign_a,    // Sign of A
    output logic              s2_sign_b,    // Sign of conditioned B
    output logic              s2_sat
);

    // Adder outputs, combinational
    logic [DATA_W-1:0] sum;
    logic              co;

    // ----------------------------------------
    // Carry-lookahead adder
    // ----------------------------------------

    cla_add #(
        .N  (DATA_W)
    ) u_cla_add (
        .a  (s1_a),
        .b  (s1_b),
        .ci (s1_ci),
        .c  (sum),
        .co (co)
    );

    // ----------------------------------------
    // Stage 2 registers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    // Signs kept for the overflow check in stage 3
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_sum    <= sum;
            s2_co     <= co;
            s2_sign_a <= s1_a[SIGN_BIT];
            s2_sign_b <= s1_b[SIGN_BIT];
            s2_sat    <= s1_sat;
        end
    end

endmodule : fxp_add_stage

`default_nettype wire

// File: fxp_addsub_pipe.sv
`default_nettype none
`timescale 1ns/10ps

module fxp_addsub_pipe
    import fxp_format_pkg::*;
    import fxp_op_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               in_valid,
    input  fxp_op_e           op,
    input  wire  [DATA_W-1:0] a,
    input  wire  [DATA_W-1:0] b,
    output logic              out_valid,
    output logic [DATA_W-1:0] result,
    output logic              ovf,
    output logic              carry
);

    // Operand stage to add stage
    logic              s1_valid;
    logic [DATA_W-1:0] s1_a;
    logic [DATA_W-1:0] s1_b;
    logic              s1_ci;
    logic              s1_sat;

    // Add stage to result stage
    logic              s2_valid;
    logic [DATA_W-1:0] s2_sum;
    logic              s2_co;
    logic              s2_sign_a;
    logic              s2_sign_b;
    logic              s2_sat;

    // ----------------------------------------
    // Stage 1, decode and condition
    // ----------------------------------------

    fxp_operand_stage u_fxp_operand_stage (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .op       (op),
        .a        (a),
        .b        (b),
        .s1_valid (s1_valid),
        .s1_a     (s1_a),
        .s1_b     (s1_b),
        .s1_ci    (s1_ci),
        .s1_sat   (s1_sat)
    );

    // ----------------------------------------
    // Stage 2, carry-lookahead add
    // ----------------------------------------

    fxp_add_stage u_fxp_add_stage (
        .clk       (clk),
        .rst       (rst),
        .s1_valid  (s1_valid),
        .s1_a      (s1_a),
        .s1_b      (s1_b),
        .s1_ci     (s1_ci),
        .s1_sat    (s1_sat),
        .s2_valid  (s2_valid),
        .s2_sum    (s2_sum),
        .s2_co     (s2_co),
        .s2_sign_a (s2_sign_a),
        .s2_sign_b (s2_sign_b),
        .s2_sat    (s2_sat)
    );

    // ----------------------------------------
    // Stage 3, overflow and saturation
    // ----------------------------------------

    fxp_result_stage u_fxp_result_stage (
        .clk       (clk),
        .rst       (rst),
        .s2_valid  (s2_valid),
        .s2_sum    (s2_sum),
        .s2_co     (s2_co),
        .s2_sign_a (s2_sign_a),
        .s2_sign_b (s2_sign_b),
        .s2_sat    (s2_sat),
        .out_valid (out_valid),
        .result    (result),
        .ovf       (ovf),
        .carry     (carry)
    );

endmodule : fxp_addsub_pipe

`default_nettype wire

// File: fxp_addsub_sva.sv
`default_nettype none
`timescale 1ns/10ps

module fxp_addsub_sva
    import fxp_format_pkg::*;
    import fxp_op_pkg::*;
(
    input wire              clk,
    input wire              rst,
    input wire              in_valid,
    input wire              out_valid,
    input wire [DATA_W-1:0] result,
    input wire [DATA_W-1:0] s2_sum,     // Wrapped sum ahead of the result register
    input wire              ovf,
    input wire              carry
);

    // ----------------------------------------
    // Latency in both directions
    // ----------------------------------------

    a_lat_issue: assert property (@(posedge clk) disable iff (rst)
        $past(in_valid, PIPE_LAT) |-> out_valid)
        else $error("out_valid missing %0d cycles after in_valid", PIPE_LAT);

    a_lat_out: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid, PIPE_LAT))
        else $error("out_valid without a matching in_valid");

    // ----------------------------------------
    // Output values
    // ----------------------------------------

    a_known: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown({result, ovf, carry}))
        else $error("unknown bits on result, ovf or carry");

    // A clamped result takes the limit opposite to the wrapped sign
    a_sat_limit: assert property (@(posedge clk) disable iff (rst)
        (out_valid && ovf && (result != $past(s2_sum))) |->
            (result == ($past(s2_sum[SIGN_BIT]) ? MAX_POS : MAX_NEG)))
        else $error("saturated result is not the limit of the overflow direction");

endmodule : fxp_addsub_sva

bind fxp_addsub_pipe fxp_addsub_sva u_fxp_addsub_sva (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result),
    .s2_sum    (s2_sum),
    .ovf       (ovf),
    .carry     (carry)
);

`default_nettype wire

// File: fxp_format_pkg.sv
`default_nettype none

package fxp_format_pkg;

    // ----------------------------------------
    // Signed fixed-point data format
    // ----------------------------------------

    // Operand and result width in bits
    // Binary point position is left to the user
    localparam int DATA_W = 16;

    // Saturation limits for two's complement
    // Largest positive, zero sign then all ones
    localparam logic [DATA_W-1:0] MAX_POS = {1'b0, {(DATA_W-1){1'b1}}};

    // Most negative, sign bit only
    localparam logic [DATA_W-1:0] MAX_NEG = {1'b1, {(DATA_W-1){1'b0}}};

    // Index of the sign bit, used by the stages
    localparam int SIGN_BIT = DATA_W - 1;

endpackage : fxp_format_pkg

`default_nettype wire

// File: fxp_op_pkg.sv
`default_nettype none

package fxp_op_pkg;

    // ----------------------------------------
    // Operations of the add/subtract unit
    // ----------------------------------------

    // Opcode encoding
    // Bit 0 selects subtract, bit 1 selects saturation
    typedef enum logic [1:0] {
        OP_ADD  = 2'b00,    // Wrapping add
        OP_SUB  = 2'b01,    // Wrapping subtract
        OP_ADDS = 2'b10,    // Saturating add
        OP_SUBS = 2'b11     // Saturating subtract
    } fxp_op_e;

    // ----------------------------------------
    // Pipeline timing
    // ----------------------------------------

    // Operand, add and result stages
    // One register each, in_valid to out_valid
    localparam int PIPE_LAT = 3;

endpackage : fxp_op_pkg

`default_nettype wire

// File: fxp_operand_stage.sv
`default_nettype none
`timescale 1ns/10ps

module fxp_operand_stage
    import fxp_format_pkg::*;
    import fxp_op_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               in_valid,     // One strobe per operation
    input  fxp_op_e           op,
    input  wire  [DATA_W-1:0] a,
    input  wire  [DATA_W-1:0] b,
    output logic              s1_valid,
    output logic [DATA_W-1:0] s1_a,
    output logic [DATA_W-1:0] s1_b,         // B or ~B
    output logic              s1_ci,        // 1 for subtract
    output logic              s1_sat        // Saturation request
);

    // Decoded opcode levels
    logic sub;
    logic sat;

    // ----------------------------------------
    // Opcode decode
    // ----------------------------------------

    always_comb begin
        sub = 1'b0;
        sat = 1'b0;
        case (op)
            OP_ADD: begin
                sub = 1'b0;
                sat = 1'b0;
            end
            OP_SUB: begin
                sub = 1'b1;
                sat = 1'b0;
            end
            OP_ADDS: begin
                sub = 1'b0;
                sat = 1'b1;
            end
            OP_SUBS: begin
                sub = 1'b1;
                sat = 1'b1;
            end
            default: begin
                sub = 1'b0;
                sat = 1'b0;
            end
        endcase
    end

    // ----------------------------------------
    // Stage 1 registers
    // ----------------------------------------

    // Valid pipeline bit
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // Operand conditioning
    // A - B is done as A + ~B + 1
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_a   <= a;
            s1_b   <= sub ? ~b : b;
            s1_ci  <= sub;
            s1_sat <= sat;
        end
    end

endmodule : fxp_operand_stage

`default_nettype wire

// File: fxp_result_stage.sv
`default_nettype none
`timescale 1ns/10ps

module fxp_result_stage
    import fxp_format_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               s2_valid,
    input  wire  [DATA_W-1:0] s2_sum,
    input  wire               s2_co,
    input  wire               s2_sign_a,
    input  wire               s2_sign_b,
    input  wire               s2_sat,
    output logic              out_valid,
    output logic [DATA_W-1:0] result,
    output logic              ovf,
    output logic              carry     // No-borrow for subtract
);

    // Combinational overflow and result
    logic              ovf_c;
    logic [DATA_W-1:0] limit;
    logic [DATA_W-1:0] result_c;

    // ----------------------------------------
    // Signed overflow
    // ----------------------------------------

    // Like signs in, different sign out
    assign ovf_c = (s2_sign_a == s2_sign_b) && (s2_sum[SIGN_BIT] != s2_sign_a);

    // ----------------------------------------
    // Saturation select
    // ----------------------------------------

    // Clamp toward the sign of the operands
    assign limit = s2_sign_a ? MAX_NEG : MAX_POS;

    // Wrapped sum unless saturation applies
    assign result_c = (ovf_c && s2_sat) ? limit : s2_sum;

    // ----------------------------------------
    // Output registers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s2_valid;
        end
    end

    // Outputs hold between valid results
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
            ovf    <= 1'b0;
            carry  <= 1'b0;
        end else if (s2_valid) begin
            result <= result_c;
            ovf    <= ovf_c;
            carry  <= s2_co;
        end
    end

endmodule : fxp_result_stage

`default_nettype wire

// File: list.f
fxp_format_pkg.sv
fxp_op_pkg.sv
cla_add.sv
fxp_operand_stage.sv
fxp_add_stage.sv
fxp_result_stage.sv
fxp_addsub_pipe.sv
fxp_addsub_sva.sv
tb_fxp_addsub_pipe.sv

// File: tb_fxp_addsub_pipe.sv
`default_nettype none
`timescale 1ns/10ps

module tb_fxp_addsub_pipe
    import fxp_format_pkg::*;
    import fxp_op_pkg::*;
();

    // Limit well above the roughly 300 cycles the tests take
    localparam int TIMEOUT_CYC = 2000;
    // Signed range of the format as plain integers
    localparam int LIM_HI = 2 ** (DATA_W - 1) - 1;
    localparam int LIM_LO = -(2 ** (DATA_W - 1));

    logic              clk;
    logic              rst;
    logic              in_valid;
    fxp_op_e           op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic              out_valid;
    logic [DATA_W-1:0] result;
    logic              ovf;
    logic              carry;

    // Expected {result, ovf, carry} and issue cycle
    // Oldest entry first
    logic [DATA_W+1:0] exp_q[$];
    int                issue_q[$];
    logic [DATA_W+1:0] ent;
    int                t_issue;
    int                cycle  = 0;
    int                errors = 0;
    int                tests  = 0;

    fxp_addsub_pipe u_fxp_addsub_pipe (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .ovf       (ovf),
        .carry     (carry)
    );

    // ----------------------------------------
    // Clock, cycle count, watchdog
    // ----------------------------------------

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        wait (cycle >= TIMEOUT_CYC);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
        $display(">>> FAIL");
        $finish;
    end

    // ----------------------------------------
    // Reference model and helpers
    // ----------------------------------------

    // Exact signed result in a 32-bit int before the range test
    function automatic logic [DATA_W+1:0] model_op(input fxp_op_e o,
                                                   input logic [DATA_W-1:0] x,
                                                   input logic [DATA_W-1:0] y);
        int                sx;
        int                sy;
        int                exact;
        logic [DATA_W:0]   usum;
        logic              sub;
        logic              sat;
        logic              v;
        logic              cy;
        logic [DATA_W-1:0] r;
        sx    = {{(32-DATA_W){x[DATA_W-1]}}, x};
        sy    = {{(32-DATA_W){y[DATA_W-1]}}, y};
        sub   = (o == OP_SUB) || (o == OP_SUBS);
        sat   = (o == OP_ADDS) || (o == OP_SUBS);
        exact = sub ? sx - sy : sx + sy;
        v     = (exact > LIM_HI) || (exact < LIM_LO);
        usum  = {1'b0, x} + {1'b0, y};
        // No borrow when A >= B unsigned
        cy    = sub ? (x >= y) : usum[DATA_W];
        if (v && sat) begin
            r = (exact > 0) ? MAX_POS : MAX_NEG;
        end else begin
            r = exact[DATA_W-1:0];
        end
        return {r, v, cy};
    endfunction

    task automatic compare_val(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] got);
        if (got !== exp) begin
            $display("error t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // Drive one operation and record what should come out
    task automatic issue_op(input fxp_op_e o, input logic [DATA_W-1:0] x,
                            input logic [DATA_W-1:0] y);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        op       = o;
        a        = x;
        b        = y;
        exp_q.push_back(model_op(o, x, y));
        issue_q.push_back(cycle);
    endtask

    task automatic go_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    // Let the pipe empty
    // Anything left over was lost
    task automatic drain_pipe();
        go_idle(PIPE_LAT + 2);
        if (exp_q.size() != 0) begin
            $display("%0d results never came out of the pipeline", exp_q.size());
            errors++;
            exp_q.delete();
            issue_q.delete();
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        tests++;
        $display("%s done, %0d errors", name, errors - e0);
    endtask

    // ----------------------------------------
    // Output monitor
    // ----------------------------------------

    // Sampled mid-cycle away from the clock edge
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid rose at t=%0t with no operation outstanding", $time);
                errors++;
            end else begin
                ent     = exp_q.pop_front();
                t_issue = issue_q.pop_front();
                if (cycle != t_issue + PIPE_LAT) begin
                    $display("error t=%0t out_valid cycle expected %0d got %0d",
                             $time, t_issue + PIPE_LAT, cycle);
                    errors++;
                end
                compare_val("result", ent[DATA_W+1:2], result);
                compare_val("ovf", DATA_W'(ent[1]), DATA_W'(ovf));
                compare_val("carry", DATA_W'(ent[0]), DATA_W'(carry));
            end
        end
    end

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    task automatic test_reset();
        int e0;
        e0 = errors;
        rst = 1'b1;
        // Fifth rising edge with reset high comes before the release
        repeat (4) begin
            @(negedge clk);
            compare_val("out_valid", '0, DATA_W'(out_valid));
            compare_val("result", '0, result);
            compare_val("ovf", '0, DATA_W'(ovf));
            compare_val("carry", '0, DATA_W'(carry));
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle pipe must stay quiet
        repeat (10) begin
            @(negedge clk);
            compare_val("out_valid", '0, DATA_W'(out_valid));
            compare_val("result", '0, result);
            compare_val("ovf", '0, DATA_W'(ovf));
            compare_val("carry", '0, DATA_W'(carry));
        end
        finish_test("test_reset", e0);
    endtask

    task automatic test_add_wrap();
        int e0;
        e0 = errors;
        issue_op(OP_ADD, 16'h1234, 16'h0101);
        issue_op(OP_ADD, 16'h7FFF, 16'h0001);   // Positive overflow
        issue_op(OP_ADD, 16'h8000, 16'hFFFF);   // Negative overflow
        issue_op(OP_ADD, 16'hFFFF, 16'h0001);   // Unsigned carry, no ovf
        issue_op(OP_ADD, 16'hC000, 16'hC000);
        issue_op(OP_ADD, 16'h4000, 16'h4000);
        drain_pipe();
        finish_test("test_add_wrap", e0);
    endtask

    task automatic test_sub_wrap();
        int e0;
        e0 = errors;
        issue_op(OP_SUB, 16'h1234, 16'h1234);   // Zero, no borrow
        issue_op(OP_SUB, 16'h0001, 16'h0002);   // Borrow
        issue_op(OP_SUB, 16'h8000, 16'h0001);
        issue_op(OP_SUB, 16'h7FFF, 16'hFFFF);
        issue_op(OP_SUB, 16'h0005, 16'h0003);
        drain_pipe();
        finish_test("test_sub_wrap", e0);
    endtask

    task automatic test_saturate();
        int e0;
        e0 = errors;
        issue_op(OP_ADDS, 16'h7FFF, 16'h0001);
        issue_op(OP_ADDS, 16'h8000, 16'h8000);
        issue_op(OP_SUBS, 16'h8000, 16'h0001);
        issue_op(OP_SUBS, 16'h7FFF, 16'h8000);
        // In range, exact result expected
        issue_op(OP_ADDS, 16'h0010, 16'h0020);
        issue_op(OP_SUBS, 16'h0010, 16'h0020);
        drain_pipe();
        finish_test("test_saturate", e0);
    endtask

    task automatic test_stream();
        int                e0;
        logic [1:0]        r;
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            r = 2'($urandom_range(3, 0));
            x = DATA_W'($urandom);
            y = DATA_W'($urandom);
            issue_op(fxp_op_e'(r), x, y);
            // Occasional bubble in the input stream
            if ($urandom_range(7, 0) == 0) begin
                go_idle(int'($urandom_range(3, 1)));
            end
        end
        drain_pipe();
        finish_test("test_stream", e0);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        void'($urandom(79640));
        rst      = 1'b1;
        in_valid = 1'b0;
        op       = OP_ADD;
        a        = '0;
        b        = '0;
        test_reset();
        test_add_wrap();
        test_sub_wrap();
        test_saturate();
        test_stream();
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : tb_fxp_addsub_pipe

`default_nettype wire
